/* cpu_pkg.sv */
package cpu_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    localparam word_t reset_pc    = 32'h0000_0000;
    localparam word_t instr_bytes = 32'd4;       // fetch step

    // primary opcodes kept by this core
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // special-function field, opcode 0
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // ID/EX register contents
    typedef struct packed {
        word_t    pc;
        logic     valid;
        alu_op_e  alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    a;        // rs value from the register file
        word_t    b;        // rt value from the register file
        word_t    imm;      // already extended
        logic     use_imm;
        logic [4:0] shamt;
        reg_idx_t wreg;
        logic     regwen;   // never set for r0
        logic     load;
        logic     store;
    } id_ex_t;

endpackage

/* pipe_if.sv */
`timescale 1ns/1ps

// EX/MEM register as seen by the memory stage
interface mem_req_if;
    cpu_pkg::word_t    pc;
    logic              valid;
    cpu_pkg::word_t    result;      // alu result or load/store address
    cpu_pkg::word_t    store_data;
    logic              load;
    logic              store;
    logic              regwen;
    cpu_pkg::reg_idx_t wreg;

    modport src (output pc, valid, result, store_data, load, store, regwen, wreg);
    modport dst (input  pc, valid, result, store_data, load, store, regwen, wreg);
endinterface

// retiring register write, also the writeback forwarding source
interface wb_if;
    cpu_pkg::word_t    pc;
    logic              regwen;
    cpu_pkg::reg_idx_t wreg;
    cpu_pkg::word_t    wdata;

    modport src (output pc, regwen, wreg, wdata);
    modport dst (input  pc, regwen, wreg, wdata);
endinterface

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    input  logic              wen,
    input  cpu_pkg::reg_idx_t wreg,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    rt_data
);

    cpu_pkg::word_t regs [1:31];    // r0 has no storage

    always_ff @(posedge clk) begin
        if (wen && wreg != '0) begin
            regs[wreg] <= wdata;
        end
    end

    // write-first, so decode sees the value retiring this cycle
    assign rs_data = (rs == '0) ? '0 : (wen && wreg == rs) ? wdata : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (wen && wreg == rt) ? wdata : regs[rt];

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    output cpu_pkg::word_t fetch_pc
);

    // fetch_pc is both the instruction SRAM address and the pc sent to decode.
    // holding it on a stall makes the SRAM return the same word one more time,
    // which decode needs after it replays the stalled instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= cpu_pkg::reset_pc;
        end else if (!stall) begin
            fetch_pc <= fetch_pc + cpu_pkg::instr_bytes;    // straight-line only
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic            clk,
    input  logic            reset,
    input  cpu_pkg::word_t  fetch_pc,
    input  cpu_pkg::word_t  instr,
    wb_if.dst               wb,
    output logic            stall,
    output cpu_pkg::id_ex_t id_ex
);

    cpu_pkg::word_t    pc_q;
    cpu_pkg::word_t    held_instr;  // instruction parked during a stall
    cpu_pkg::word_t    cur;
    logic              valid_q;
    logic              replay_q;
    logic              live;
    cpu_pkg::opcode_e  opcode;
    cpu_pkg::funct_e   funct;
    cpu_pkg::reg_idx_t rs, rt;
    cpu_pkg::word_t    rs_data, rt_data;
    cpu_pkg::id_ex_t   next;
    logic              reads_rs, reads_rt;

    assign cur    = replay_q ? held_instr : instr;  // sram word is stale after a stall
    assign opcode = cpu_pkg::opcode_e'(cur[31:26]);
    assign funct  = cpu_pkg::funct_e'(cur[5:0]);
    assign rs     = cur[25:21];
    assign rt     = cur[20:16];

    regfile u_regfile (
        .clk     (clk),
        .rs      (rs),
        .rt      (rt),
        .wen     (wb.regwen),
        .wreg    (wb.wreg),
        .wdata   (wb.wdata),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    always_comb begin
        next         = '0;
        next.pc      = pc_q;
        next.rs      = rs;
        next.rt      = rt;
        next.a       = rs_data;
        next.b       = rt_data;
        next.shamt   = cur[10:6];
        next.alu_op  = cpu_pkg::alu_add;
        next.imm     = {{16{cur[15]}}, cur[15:0]};   // sign extend by default
        next.use_imm = 1'b1;
        next.wreg    = rt;
        next.regwen  = 1'b1;
        reads_rs     = 1'b1;
        reads_rt     = 1'b0;
        case (opcode)
            cpu_pkg::op_special: begin
                next.use_imm = 1'b0;
                next.wreg    = cur[15:11];
                reads_rt     = 1'b1;
                case (funct)
                    cpu_pkg::fn_addu: next.alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: next.alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  next.alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   next.alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  next.alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_nor:  next.alu_op = cpu_pkg::alu_nor;
                    cpu_pkg::fn_slt:  next.alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sltu: next.alu_op = cpu_pkg::alu_sltu;
                    cpu_pkg::fn_sll: begin next.alu_op = cpu_pkg::alu_sll; reads_rs = 1'b0; end
                    cpu_pkg::fn_srl: begin next.alu_op = cpu_pkg::alu_srl; reads_rs = 1'b0; end
                    cpu_pkg::fn_sra: begin next.alu_op = cpu_pkg::alu_sra; reads_rs = 1'b0; end
                    default:          next.regwen = 1'b0;   // unknown funct is a nop
                endcase
            end
            cpu_pkg::op_addiu: next.alu_op = cpu_pkg::alu_add;
            cpu_pkg::op_slti:  next.alu_op = cpu_pkg::alu_slt;
            cpu_pkg::op_sltiu: next.alu_op = cpu_pkg::alu_sltu;   // compares against sign-extended imm
            cpu_pkg::op_andi: begin
                next.alu_op = cpu_pkg::alu_and;
                next.imm    = {16'h0, cur[15:0]};
            end
            cpu_pkg::op_ori: begin
                next.alu_op = cpu_pkg::alu_or;
                next.imm    = {16'h0, cur[15:0]};
            end
            cpu_pkg::op_xori: begin
                next.alu_op = cpu_pkg::alu_xor;
                next.imm    = {16'h0, cur[15:0]};
            end
            cpu_pkg::op_lui: begin
                next.alu_op = cpu_pkg::alu_lui;
                next.imm    = {cur[15:0], 16'h0};
                reads_rs    = 1'b0;
            end
            cpu_pkg::op_lw: next.load = 1'b1;
            cpu_pkg::op_sw: begin
                next.store  = 1'b1;
                next.regwen = 1'b0;
                reads_rt    = 1'b1;
            end
            default: next.regwen = 1'b0;
        endcase
        next.valid  = live;
        next.regwen = next.regwen && live && next.wreg != '0;
        next.load   = next.load && live;
        next.store  = next.store && live;
    end

    // load in ID/EX feeding the instruction here, its data is not ready until writeback
    assign stall = valid_q && id_ex.load && id_ex.regwen
                   && ((reads_rs && id_ex.wreg == rs) || (reads_rt && id_ex.wreg == rt));
    assign live  = valid_q && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q      <= 1'b0;
            replay_q     <= 1'b0;
            id_ex.valid  <= 1'b0;
            id_ex.regwen <= 1'b0;
            id_ex.load   <= 1'b0;
            id_ex.store  <= 1'b0;
        end else begin
            valid_q  <= 1'b1;
            replay_q <= stall;
            id_ex    <= next;   // bubble when stalled
        end
        if (!stall) pc_q <= fetch_pc;
        if (stall) held_instr <= cur;
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            reset,
    input  cpu_pkg::id_ex_t id_ex,
    wb_if.dst               wb,
    mem_req_if.src          mem
);

    cpu_pkg::word_t fwd_a, fwd_b;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t result;
    logic           mem_fwd_ok;

    // EX/MEM holds the memory stage's result; a load there has no data yet.
    // regwen is never set for r0, so r0 is never forwarded
    assign mem_fwd_ok = mem.regwen && !mem.load;

    assign fwd_a = (mem_fwd_ok && mem.wreg == id_ex.rs) ? mem.result :
                   (wb.regwen && wb.wreg == id_ex.rs)   ? wb.wdata   : id_ex.a;
    assign fwd_b = (mem_fwd_ok && mem.wreg == id_ex.rt) ? mem.result :
                   (wb.regwen && wb.wreg == id_ex.rt)   ? wb.wdata   : id_ex.b;

    assign op_b = id_ex.use_imm ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::alu_add:  result = fwd_a + op_b;   // wraps, no overflow trap
            cpu_pkg::alu_sub:  result = fwd_a - op_b;
            cpu_pkg::alu_and:  result = fwd_a & op_b;
            cpu_pkg::alu_or:   result = fwd_a | op_b;
            cpu_pkg::alu_xor:  result = fwd_a ^ op_b;
            cpu_pkg::alu_nor:  result = ~(fwd_a | op_b);
            cpu_pkg::alu_slt:  result = {31'h0, $signed(fwd_a) < $signed(op_b)};
            cpu_pkg::alu_sltu: result = {31'h0, fwd_a < op_b};
            cpu_pkg::alu_sll:  result = op_b << id_ex.shamt;
            cpu_pkg::alu_srl:  result = op_b >> id_ex.shamt;
            cpu_pkg::alu_sra:  result = $signed(op_b) >>> id_ex.shamt;
            cpu_pkg::alu_lui:  result = op_b;           // imm already in the upper half
            default:           result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem.valid  <= 1'b0;
            mem.regwen <= 1'b0;
            mem.load   <= 1'b0;
            mem.store  <= 1'b0;
        end else begin
            mem.valid  <= id_ex.valid;
            mem.regwen <= id_ex.regwen;
            mem.load   <= id_ex.load;
            mem.store  <= id_ex.store;
        end
        mem.pc         <= id_ex.pc;
        mem.result     <= result;
        mem.store_data <= fwd_b;    // sw data, forwarded like any rt read
        mem.wreg       <= id_ex.wreg;
    end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic           clk,
    input  logic           reset,
    mem_req_if.dst         mem,
    output logic           data_sram_en,
    output logic [3:0]     data_sram_wen,
    output cpu_pkg::word_t data_sram_addr,
    output cpu_pkg::word_t data_sram_wdata,
    input  cpu_pkg::word_t data_sram_rdata,
    wb_if.src              wb
);

    cpu_pkg::word_t wb_result;
    logic           wb_load;

    // word accesses only
    assign data_sram_en    = mem.valid && (mem.load || mem.store);
    assign data_sram_wen   = {4{mem.valid && mem.store}};
    assign data_sram_addr  = {mem.result[cpu_pkg::data_w-1:2], 2'b00};
    assign data_sram_wdata = mem.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.regwen <= 1'b0;
            wb_load   <= 1'b0;
        end else begin
            wb.regwen <= mem.valid && mem.regwen;
            wb_load   <= mem.valid && mem.load;
        end
        wb.pc     <= mem.pc;
        wb.wreg   <= mem.wreg;
        wb_result <= mem.result;
    end

    // sram read data shows up one cycle after the address, i.e. in writeback
    assign wb.wdata = wb_load ? data_sram_rdata : wb_result;

endmodule

/* mycpu_top.sv */
`timescale 1ns/1ps

module mycpu_top (
    input  logic              clk,
    input  logic              reset,
    output cpu_pkg::word_t    inst_sram_addr,
    input  cpu_pkg::word_t    inst_sram_rdata,
    output logic              data_sram_en,
    output logic [3:0]        data_sram_wen,
    output cpu_pkg::word_t    data_sram_addr,
    output cpu_pkg::word_t    data_sram_wdata,
    input  cpu_pkg::word_t    data_sram_rdata,
    output cpu_pkg::word_t    debug_wb_pc,
    output logic [3:0]        debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);

    cpu_pkg::id_ex_t id_ex;
    logic            stall;

    mem_req_if mem_bus ();
    wb_if      wb_bus ();

    fetch_stage u_fetch (.clk(clk), .reset(reset), .stall(stall), .fetch_pc(inst_sram_addr));

    decode_stage u_decode (
        .clk(clk), .reset(reset), .fetch_pc(inst_sram_addr), .instr(inst_sram_rdata),
        .wb(wb_bus), .stall(stall), .id_ex(id_ex)
    );

    execute_stage u_execute (.clk(clk), .reset(reset), .id_ex(id_ex), .wb(wb_bus), .mem(mem_bus));

    memory_stage u_memory (
        .clk(clk), .reset(reset), .mem(mem_bus),
        .data_sram_en(data_sram_en), .data_sram_wen(data_sram_wen),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata), .wb(wb_bus)
    );

    // retire trace
    assign debug_wb_pc       = wb_bus.pc;
    assign debug_wb_rf_wen   = {4{wb_bus.regwen}};
    assign debug_wb_rf_wnum  = wb_bus.wreg;
    assign debug_wb_rf_wdata = wb_bus.wdata;

endmodule

/* cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions (
    input logic              clk,
    input logic              reset,
    input cpu_pkg::word_t    inst_sram_addr,
    input logic              data_sram_en,
    input logic [3:0]        data_sram_wen,
    input logic [3:0]        debug_wb_rf_wen,
    input cpu_pkg::reg_idx_t debug_wb_rf_wnum
);

    // the SRAM ignores a write strobe without its enable
    wen_has_en: assert property (@(posedge clk) disable iff (reset)
        data_sram_wen != 4'h0 |-> data_sram_en)
        else $error("data_sram_wen set without data_sram_en");

    no_r0_write: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != '0)
        else $error("retired register write names r0");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_sram_addr[1:0] == 2'b00)
        else $error("instruction fetch address is not word aligned");

    // straight-line code, so the pc only holds (stall) or steps
    fetch_step: assert property (@(posedge clk) disable iff (reset)
        inst_sram_addr == $past(inst_sram_addr)
        || inst_sram_addr == $past(inst_sram_addr) + 32'd4)
        else $error("instruction fetch address jumped");

endmodule

bind mycpu_top cpu_assertions u_assertions (
    .clk              (clk),
    .reset            (reset),
    .inst_sram_addr   (inst_sram_addr),
    .data_sram_en     (data_sram_en),
    .data_sram_wen    (data_sram_wen),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    localparam int          prog_len       = 200;
    localparam int          timeout_cycles = 2 * prog_len + 40;
    localparam logic [31:0] lfsr_seed      = 32'd85822;

    // one expected retirement, either a register write or a store
    typedef struct packed {
        logic              is_write;
        logic              is_store;
        cpu_pkg::word_t    pc;
        cpu_pkg::reg_idx_t wreg;
        cpu_pkg::word_t    data;   // write value or store data
        cpu_pkg::word_t    addr;
    } expect_t;

    logic              clk;
    logic              reset;
    cpu_pkg::word_t    inst_sram_addr;
    cpu_pkg::word_t    inst_sram_rdata;
    logic              data_sram_en;
    logic [3:0]        data_sram_wen;
    cpu_pkg::word_t    data_sram_addr;
    cpu_pkg::word_t    data_sram_wdata;
    cpu_pkg::word_t    data_sram_rdata;
    cpu_pkg::word_t    debug_wb_pc;
    logic [3:0]        debug_wb_rf_wen;
    cpu_pkg::reg_idx_t debug_wb_rf_wnum;
    cpu_pkg::word_t    debug_wb_rf_wdata;

    cpu_pkg::word_t imem [0:255];       // program, then zero words
    cpu_pkg::word_t sram_mem [0:63];    // data SRAM behind the DUT
    cpu_pkg::word_t ref_mem [0:63];
    cpu_pkg::word_t ref_regs [0:31];
    logic [31:0]    lfsr_state;
    expect_t        write_q [$];
    expect_t        store_q [$];

    // requests seen this cycle, answered after the next edge
    cpu_pkg::word_t inst_addr_q;
    cpu_pkg::word_t data_addr_q;
    cpu_pkg::word_t data_wdata_q;
    logic           data_en_q;
    logic [3:0]     data_wen_q;

    mycpu_top dut0 (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic cpu_pkg::word_t rand_bits(int n);
        cpu_pkg::word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic cpu_pkg::word_t make_instr(int slot);
        cpu_pkg::reg_idx_t rs;
        cpu_pkg::reg_idx_t rt;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::word_t    instr;
        logic [5:0]        op;
        logic [5:0]        fn;
        logic [4:0]        sh;
        logic [15:0]       offset;
        int                kind;
        int                pick;
        rs    = 5'(rand_bits(3));    // r0..r7 keeps hazards frequent
        rt    = 5'(rand_bits(3));
        rd    = 5'(rand_bits(3));
        kind  = int'(rand_bits(4));
        instr = '0;
        if (slot < 7) begin
            // r1..r7 get a known value before anything reads them
            op    = cpu_pkg::op_addiu;
            instr = {op, 5'd0, 5'(slot + 1), 16'(rand_bits(16))};
        end else if (kind < 6) begin
            pick = int'(rand_bits(4)) % 11;
            sh   = 5'd0;
            case (pick)
                0:       fn = cpu_pkg::fn_addu;
                1:       fn = cpu_pkg::fn_subu;
                2:       fn = cpu_pkg::fn_and;
                3:       fn = cpu_pkg::fn_or;
                4:       fn = cpu_pkg::fn_xor;
                5:       fn = cpu_pkg::fn_nor;
                6:       fn = cpu_pkg::fn_slt;
                7:       fn = cpu_pkg::fn_sltu;
                8:       fn = cpu_pkg::fn_sll;
                9:       fn = cpu_pkg::fn_srl;
                default: fn = cpu_pkg::fn_sra;
            endcase
            if (pick >= 8) begin
                rs = 5'd0;
                sh = 5'(rand_bits(5));
            end
            instr = {6'h00, rs, rt, rd, sh, fn};
        end else if (kind < 11) begin
            case (int'(rand_bits(3)) % 7)
                0:       op = cpu_pkg::op_addiu;
                1:       op = cpu_pkg::op_slti;
                2:       op = cpu_pkg::op_sltiu;
                3:       op = cpu_pkg::op_andi;
                4:       op = cpu_pkg::op_ori;
                5:       op = cpu_pkg::op_xori;
                default: begin
                    op = cpu_pkg::op_lui;
                    rs = 5'd0;
                end
            endcase
            instr = {op, rs, rt, 16'(rand_bits(16))};
        end else if (kind < 15 || rand_bits(1) == 32'd1) begin
            op = (kind < 14) ? cpu_pkg::op_lw : cpu_pkg::op_sw;
            // half the accesses hit the low 8 words so loads find earlier stores
            offset = (rand_bits(1) == 32'd1) ? 16'(rand_bits(6) << 2) : 16'(rand_bits(3) << 2);
            instr  = {op, 5'd0, rt, offset};
        end
        return instr;
    endfunction

    // reference interpreter, one instruction over the model state
    function automatic expect_t interpret(cpu_pkg::word_t pc, cpu_pkg::word_t instr);
        expect_t           e;
        logic [5:0]        op;
        logic [5:0]        fn;
        logic [4:0]        sh;
        cpu_pkg::reg_idx_t dest;
        cpu_pkg::word_t    va;
        cpu_pkg::word_t    vb;
        cpu_pkg::word_t    sext;
        cpu_pkg::word_t    zext;
        cpu_pkg::word_t    value;
        cpu_pkg::word_t    addr;
        logic              writes;
        e      = '0;
        e.pc   = pc;
        op     = instr[31:26];
        fn     = instr[5:0];
        sh     = instr[10:6];
        dest   = instr[20:16];
        va     = ref_regs[instr[25:21]];
        vb     = ref_regs[instr[20:16]];
        sext   = {{16{instr[15]}}, instr[15:0]};
        zext   = {16'h0, instr[15:0]};
        addr   = va + sext;
        value  = '0;
        writes = 1'b1;
        case (op)
            cpu_pkg::op_special: begin
                dest = instr[15:11];
                case (fn)
                    cpu_pkg::fn_addu: value = va + vb;
                    cpu_pkg::fn_subu: value = va - vb;
                    cpu_pkg::fn_and:  value = va & vb;
                    cpu_pkg::fn_or:   value = va | vb;
                    cpu_pkg::fn_xor:  value = va ^ vb;
                    cpu_pkg::fn_nor:  value = ~(va | vb);
                    cpu_pkg::fn_slt:  value = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
                    cpu_pkg::fn_sltu: value = (va < vb) ? 32'd1 : 32'd0;
                    cpu_pkg::fn_sll:  value = vb << sh;
                    cpu_pkg::fn_srl:  value = vb >> sh;
                    cpu_pkg::fn_sra:  value = cpu_pkg::word_t'($signed(vb) >>> sh);
                    default:          writes = 1'b0;
                endcase
            end
            cpu_pkg::op_addiu: value = va + sext;
            cpu_pkg::op_slti:  value = ($signed(va) < $signed(sext)) ? 32'd1 : 32'd0;
            cpu_pkg::op_sltiu: value = (va < sext) ? 32'd1 : 32'd0;
            cpu_pkg::op_andi:  value = va & zext;
            cpu_pkg::op_ori:   value = va | zext;
            cpu_pkg::op_xori:  value = va ^ zext;
            cpu_pkg::op_lui:   value = {instr[15:0], 16'h0};
            cpu_pkg::op_lw:    value = ref_mem[addr[7:2]];
            cpu_pkg::op_sw: begin
                writes     = 1'b0;
                e.is_store = 1'b1;
                e.addr     = {addr[31:2], 2'b00};
                e.data     = vb;
                ref_mem[addr[7:2]] = vb;
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != 5'd0) begin
            ref_regs[dest] = value;
            e.is_write     = 1'b1;
            e.wreg         = dest;
            e.data         = value;
        end
        return e;
    endfunction

    function automatic cpu_pkg::word_t fetch_word(cpu_pkg::word_t addr);
        if (addr[31:10] != '0) begin
            return '0;
        end else begin
            return imem[addr[9:2]];
        end
    endfunction

    task automatic fail_run(string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic check_write(cpu_pkg::word_t pc, logic [3:0] wen,
                               cpu_pkg::reg_idx_t wnum, cpu_pkg::word_t wdata);
        expect_t e;
        if (write_q.size() == 0) begin
            fail_run("a register write retired after every expected write was seen");
        end else begin
            e = write_q.pop_front();
            if (pc !== e.pc || wnum !== e.wreg || wdata !== e.data || wen !== 4'hf) begin
                fail_run($sformatf("Error at %0t: write pc %h r%0d = %h wen %h, expected pc %h r%0d = %h",
                                   $time, pc, wnum, wdata, wen, e.pc, e.wreg, e.data));
            end
        end
    endtask

    task automatic check_store(cpu_pkg::word_t addr, logic [3:0] wen, cpu_pkg::word_t wdata);
        expect_t e;
        if (store_q.size() == 0) begin
            fail_run("the data SRAM was written after every expected store was seen");
        end else begin
            e = store_q.pop_front();
            if (addr !== e.addr || wdata !== e.data || wen !== 4'hf) begin
                fail_run($sformatf("Error at %0t: store [%h] = %h wen %h, expected [%h] = %h",
                                   $time, addr, wdata, wen, e.addr, e.data));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        expect_t e;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        inst_addr_q     = '0;
        data_addr_q     = '0;
        data_wdata_q    = '0;
        data_en_q       = 1'b0;
        data_wen_q      = 4'h0;
        lfsr_state      = lfsr_seed;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            sram_mem[i] = cpu_pkg::word_t'(32'h5eed_0000 + i * 4);   // tracks the address
            ref_mem[i]  = sram_mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = make_instr(i);
            e = interpret(cpu_pkg::word_t'(i * 4), imem[i]);
            if (e.is_write) write_q.push_back(e);
            if (e.is_store) store_q.push_back(e);
        end
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
    end

    // both SRAMs, one clock of read latency
    initial begin
        forever begin
            @(posedge clk);
            #1;
            inst_sram_rdata = fetch_word(inst_addr_q);
            if (data_en_q) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_wen_q[b]) sram_mem[data_addr_q[7:2]][8*b +: 8] = data_wdata_q[8*b +: 8];
                end
                data_sram_rdata = sram_mem[data_addr_q[7:2]];
            end
            @(negedge clk);
            inst_addr_q  = inst_sram_addr;
            data_en_q    = data_sram_en;
            data_wen_q   = data_sram_wen;
            data_addr_q  = data_sram_addr;
            data_wdata_q = data_sram_wdata;
        end
    end

    // compares retired writes and stores in order, at mid-cycle
    initial begin
        int cycles;
        cycles = 0;
        @(posedge clk);
        @(negedge clk);
        while (reset === 1'b1) begin
            if (debug_wb_rf_wen !== 4'h0 || data_sram_en !== 1'b0) begin
                fail_run("the DUT wrote a register or the data SRAM while reset was held");
            end
            @(negedge clk);
        end
        if (inst_sram_addr !== 32'h0000_0000) begin
            fail_run($sformatf("Error at %0t: first fetch address %h, expected 00000000",
                               $time, inst_sram_addr));
        end
        while ((write_q.size() != 0 || store_q.size() != 0) && cycles < timeout_cycles) begin
            if (debug_wb_rf_wen !== 4'h0) begin
                check_write(debug_wb_pc, debug_wb_rf_wen, debug_wb_rf_wnum, debug_wb_rf_wdata);
            end
            if (data_sram_wen !== 4'h0) begin
                check_store(data_sram_addr, data_sram_wen, data_sram_wdata);
            end
            cycles++;
            @(negedge clk);
        end
        if (write_q.size() == 0 && store_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run($sformatf("the run timed out after %0d cycles, %0d writes and %0d stores missing",
                               cycles, write_q.size(), store_q.size()));
        end
    end

endmodule

/* list.f */
cpu_pkg.sv
pipe_if.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mycpu_top.sv
cpu_assertions.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
# compile and run tb_cpu with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_cpu -Mdir obj_dir -o sim_tb_cpu
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_cpu 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
